/* design/frontend_pkg.sv */
package frontend_pkg;

    // loongarch encodings
    localparam logic [31:0] INST_IBAR = 32'h3872_8000;
    localparam logic [31:0] INST_NOP  = 32'h0340_0000;  // andi r0, r0, 0

    localparam logic [31:0] INST_BYTES = 32'd4;
    localparam logic [31:0] PAIR_BYTES = 32'd8;

    typedef enum logic [1:0] {
        OP_NORMAL = 2'b00,
        OP_IBAR   = 2'b01
    } op_class_e;

    // gray-ish order, one bit flips per step
    typedef enum logic [1:0] {
        IDLE            = 2'b00,
        WAIT_EX_IBAR    = 2'b01,
        WAIT_CACHE_IDLE = 2'b11,
        WAIT_FETCH      = 2'b10
    } ibar_state_e;

    typedef struct packed {
        logic [31:0] pc;
    } fetch_req_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst0;
        logic [31:0] inst1;
        logic [6:0]  excp;     // 0 = no exception
    } fetch_resp_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] pc_next;
        logic [31:0] inst0;
        logic [31:0] inst1;
        logic [6:0]  excp;
        logic [1:0]  slot_valid;  // bit0 = slot0
    } fetch_pkt_t;

endpackage

/* design/pc_gen.sv */
module pc_gen #(
    parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     fetch_en,
    input  logic                     stage_free,
    input  logic                     redirect_valid,
    input  logic [31:0]              redirect_pc,
    input  logic                     resume_valid,
    input  logic [31:0]              resume_pc,
    output frontend_pkg::fetch_req_t imem_req,
    output logic                     imem_req_valid,
    input  logic                     imem_req_ready,
    input  logic                     imem_resp_valid,
    output logic                     resp_take
);

    logic [31:0] pc;
    logic        outstanding;
    logic        discard;     // reply in flight belongs to a flushed stream
    logic        req_fire;

    assign imem_req_valid = fetch_en && stage_free && !outstanding;
    assign imem_req       = '{pc: pc};
    assign req_fire       = imem_req_valid && imem_req_ready;

    // redirect in the same cycle drops the reply too
    assign resp_take = imem_resp_valid && outstanding && !discard && !redirect_valid;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc          <= RESET_PC;
            outstanding <= 1'b0;
            discard     <= 1'b0;
        end else begin
            if (req_fire)
                outstanding <= 1'b1;
            else if (imem_resp_valid)
                outstanding <= 1'b0;

            if (redirect_valid)
                discard <= req_fire || (outstanding && !imem_resp_valid);
            else if (imem_resp_valid)
                discard <= 1'b0;

            if (redirect_valid)
                pc <= redirect_pc;
            else if (resume_valid)
                pc <= resume_pc;
            else if (resp_take)
                pc <= pc + frontend_pkg::PAIR_BYTES;
        end
    end

endmodule

/* design/predecode.sv */
module predecode (
    input  frontend_pkg::fetch_resp_t resp,
    output logic [1:0]                ibar_flag,
    output logic [1:0]                slot_valid
);

    frontend_pkg::op_class_e cls0;
    frontend_pkg::op_class_e cls1;

    // only the barrier is told apart for now
    function automatic frontend_pkg::op_class_e classify(input logic [31:0] inst);
        frontend_pkg::op_class_e cls;
        case (inst)
            frontend_pkg::INST_IBAR: cls = frontend_pkg::OP_IBAR;
            default:                 cls = frontend_pkg::OP_NORMAL;
        endcase
        return cls;
    endfunction

    assign cls0 = classify(resp.inst0);
    assign cls1 = classify(resp.inst1);

    // anything behind a barrier in slot0 is refetched later
    assign slot_valid[0] = 1'b1;
    assign slot_valid[1] = (cls0 != frontend_pkg::OP_IBAR);

    assign ibar_flag[0] = (cls0 == frontend_pkg::OP_IBAR);
    assign ibar_flag[1] = (cls1 == frontend_pkg::OP_IBAR) && slot_valid[1];

endmodule

/* design/ibar_ctrl.sv */
module ibar_ctrl #(
    parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
    input  logic        clk,
    input  logic        rstn,
    input  logic        redirect_valid,
    input  logic        resp_take,
    input  logic [31:0] resp_pc,
    input  logic [1:0]  ibar_flag,
    input  logic        ex_ibar_done,
    input  logic        cache_idle,
    output logic        fetch_en,
    output logic        resume_valid,
    output logic [31:0] resume_pc
);

    frontend_pkg::ibar_state_e state;
    frontend_pkg::ibar_state_e state_nxt;

    logic ibar_hit;
    logic resume_hit;
    logic fetch_state;

    assign ibar_hit    = resp_take && (ibar_flag != 2'b00);
    assign resume_hit  = resp_take && (resp_pc == resume_pc);
    assign fetch_state = (state == frontend_pkg::IDLE) || (state == frontend_pkg::WAIT_FETCH);

    always_comb begin
        state_nxt = state;
        case (state)
            frontend_pkg::IDLE: begin
                if (ibar_hit)
                    state_nxt = frontend_pkg::WAIT_EX_IBAR;
            end
            frontend_pkg::WAIT_EX_IBAR: begin
                if (ex_ibar_done)
                    state_nxt = frontend_pkg::WAIT_CACHE_IDLE;
            end
            frontend_pkg::WAIT_CACHE_IDLE: begin
                if (cache_idle)
                    state_nxt = frontend_pkg::WAIT_FETCH;
            end
            frontend_pkg::WAIT_FETCH: begin
                // resumed pair may itself hold another barrier
                if (resume_hit)
                    state_nxt = ibar_hit ? frontend_pkg::WAIT_EX_IBAR : frontend_pkg::IDLE;
            end
            default: state_nxt = frontend_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= frontend_pkg::IDLE;
            resume_pc <= RESET_PC;
        end else begin
            if (redirect_valid)
                state <= frontend_pkg::IDLE;
            else
                state <= state_nxt;

            if (ibar_hit && fetch_state && !redirect_valid)
                resume_pc <= ibar_flag[0] ? resp_pc + frontend_pkg::INST_BYTES
                                          : resp_pc + frontend_pkg::PAIR_BYTES;
        end
    end

    assign fetch_en     = fetch_state;
    assign resume_valid = (state == frontend_pkg::WAIT_CACHE_IDLE) && cache_idle;  // one pulse

endmodule

/* design/fetch_stage_reg.sv */
module fetch_stage_reg (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      redirect_valid,
    input  frontend_pkg::fetch_resp_t resp,
    input  logic                      resp_take,
    input  logic [1:0]                slot_valid,
    output frontend_pkg::fetch_pkt_t  pkt,
    output logic                      pkt_valid,
    input  logic                      pkt_ready,
    output logic                      stage_free
);

    frontend_pkg::fetch_pkt_t pkt_d;
    logic                     pkt_fire;

    assign pkt_fire = pkt_valid && pkt_ready;

    // nop fill for masked slots
    always_comb begin
        pkt_d.pc         = resp.pc;
        pkt_d.pc_next    = resp.pc + frontend_pkg::PAIR_BYTES;
        pkt_d.inst0      = slot_valid[0] ? resp.inst0 : frontend_pkg::INST_NOP;
        pkt_d.inst1      = slot_valid[1] ? resp.inst1 : frontend_pkg::INST_NOP;
        pkt_d.excp       = resp.excp;
        pkt_d.slot_valid = slot_valid;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pkt_valid <= 1'b0;
        end else if (redirect_valid) begin
            pkt_valid <= 1'b0;
        end else if (resp_take) begin
            pkt_valid <= 1'b1;
        end else if (pkt_fire) begin
            pkt_valid <= 1'b0;
        end
    end

    // payload holds otherwise
    always_ff @(posedge clk) begin
        if (resp_take)
            pkt <= pkt_d;
    end

    assign stage_free = !pkt_valid || pkt_ready;

endmodule

/* design/fetch_buffer.sv */
module fetch_buffer #(
    parameter int unsigned BUF_DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     redirect_valid,
    input  frontend_pkg::fetch_pkt_t in_pkt,
    input  logic                     in_valid,
    output logic                     in_ready,
    output frontend_pkg::fetch_pkt_t out_pkt,
    output logic                     out_valid,
    input  logic                     out_ready
);

    localparam int unsigned PTR_W = $clog2(BUF_DEPTH);
    localparam int unsigned CNT_W = PTR_W + 1;

    frontend_pkg::fetch_pkt_t mem [BUF_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    assign in_ready  = (count != CNT_W'(BUF_DEPTH));
    assign out_valid = (count != '0);
    assign wr_en     = in_valid && in_ready;
    assign rd_en     = out_valid && out_ready;

    assign out_pkt = mem[rd_ptr];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (redirect_valid) begin
            // flush drops every queued pair
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;

            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr] <= in_pkt;
    end

endmodule

/* design/fetch_frontend.sv */
module fetch_frontend #(
    parameter logic [31:0] RESET_PC  = 32'h1c00_0000,
    parameter int unsigned BUF_DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      rstn,
    output frontend_pkg::fetch_req_t  imem_req,
    output logic                      imem_req_valid,
    input  logic                      imem_req_ready,
    input  frontend_pkg::fetch_resp_t imem_resp,
    input  logic                      imem_resp_valid,
    input  logic                      ex_ibar_done,
    input  logic                      cache_idle,
    input  logic                      redirect_valid,
    input  logic [31:0]               redirect_pc,
    output frontend_pkg::fetch_pkt_t  dec_pkt,
    output logic                      dec_valid,
    input  logic                      dec_ready
);

    logic                     fetch_en;
    logic                     stage_free;
    logic                     resp_take;
    logic                     resume_valid;
    logic [31:0]              resume_pc;
    logic [1:0]               ibar_flag;
    logic [1:0]               slot_valid;
    frontend_pkg::fetch_pkt_t pkt;
    logic                     pkt_valid;
    logic                     pkt_ready;

    pc_gen #(.RESET_PC(RESET_PC)) u_pc_gen (
        .clk             (clk),
        .rstn            (rstn),
        .fetch_en        (fetch_en),
        .stage_free      (stage_free),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .resume_valid    (resume_valid),
        .resume_pc       (resume_pc),
        .imem_req        (imem_req),
        .imem_req_valid  (imem_req_valid),
        .imem_req_ready  (imem_req_ready),
        .imem_resp_valid (imem_resp_valid),
        .resp_take       (resp_take)
    );

    predecode u_predecode (
        .resp       (imem_resp),
        .ibar_flag  (ibar_flag),
        .slot_valid (slot_valid)
    );

    ibar_ctrl #(.RESET_PC(RESET_PC)) u_ibar_ctrl (
        .clk            (clk),
        .rstn           (rstn),
        .redirect_valid (redirect_valid),
        .resp_take      (resp_take),
        .resp_pc        (imem_resp.pc),
        .ibar_flag      (ibar_flag),
        .ex_ibar_done   (ex_ibar_done),
        .cache_idle     (cache_idle),
        .fetch_en       (fetch_en),
        .resume_valid   (resume_valid),
        .resume_pc      (resume_pc)
    );

    fetch_stage_reg u_fetch_stage_reg (
        .clk            (clk),
        .rstn           (rstn),
        .redirect_valid (redirect_valid),
        .resp           (imem_resp),
        .resp_take      (resp_take),
        .slot_valid     (slot_valid),
        .pkt            (pkt),
        .pkt_valid      (pkt_valid),
        .pkt_ready      (pkt_ready),
        .stage_free     (stage_free)
    );

    fetch_buffer #(.BUF_DEPTH(BUF_DEPTH)) u_fetch_buffer (
        .clk            (clk),
        .rstn           (rstn),
        .redirect_valid (redirect_valid),
        .in_pkt         (pkt),
        .in_valid       (pkt_valid),
        .in_ready       (pkt_ready),
        .out_pkt        (dec_pkt),
        .out_valid      (dec_valid),
        .out_ready      (dec_ready)
    );

endmodule

/* sim/tb_fetch_frontend.sv */
module tb_fetch_frontend;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] RESET_PC = 32'h1c00_0000;
    localparam int          NUM_ROWS = 6;

    typedef struct packed {
        logic [31:0] start_pc;
        logic [31:0] ibar_addr;    // 0 = no barrier
        logic [31:0] redir_cycle;  // 0 = no mid-stream redirect
        logic [31:0] redir_pc;
        logic [31:0] excp_addr;    // 0 = no exception
        logic [6:0]  excp_code;
        logic [31:0] ex_dly;
        logic [31:0] ci_dly;
        logic [31:0] duty;         // dec_ready percent
        logic [31:0] n_pkts;
    } row_t;

    logic                      clk;
    logic                      rstn = 1'b0;
    frontend_pkg::fetch_req_t  imem_req;
    logic                      imem_req_valid;
    logic                      imem_req_ready = 1'b0;
    frontend_pkg::fetch_resp_t imem_resp = '0;
    logic                      imem_resp_valid = 1'b0;
    logic                      ex_ibar_done = 1'b0;
    logic                      cache_idle = 1'b0;
    logic                      redirect_valid = 1'b0;
    logic [31:0]               redirect_pc = '0;
    frontend_pkg::fetch_pkt_t  dec_pkt;
    logic                      dec_valid;
    logic                      dec_ready = 1'b0;

    row_t        rows [NUM_ROWS];
    int          row_idx = 0;
    int          pkt_count = 0;
    int          cycles = 0;
    int          limit;
    logic [31:0] exp_req_pc = RESET_PC;
    logic [31:0] exp_pkt_pc = RESET_PC;
    logic        blocked = 1'b0;  // barrier pending, no request allowed
    logic        ex_seen = 1'b0;  // execute side done for the pending barrier
    int          ex_wait = -1;
    int          ci_wait = -1;

    fetch_frontend #(.RESET_PC(RESET_PC), .BUF_DEPTH(4)) u_fetch_frontend (
        .clk             (clk),
        .rstn            (rstn),
        .imem_req        (imem_req),
        .imem_req_valid  (imem_req_valid),
        .imem_req_ready  (imem_req_ready),
        .imem_resp       (imem_resp),
        .imem_resp_valid (imem_resp_valid),
        .ex_ibar_done    (ex_ibar_done),
        .cache_idle      (cache_idle),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .dec_pkt         (dec_pkt),
        .dec_valid       (dec_valid),
        .dec_ready       (dec_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // memory image of the current row
    function automatic logic [31:0] word_at(input logic [31:0] a);
        if (a == rows[row_idx].ibar_addr)
            return frontend_pkg::INST_IBAR;
        return {~a[31], a[30:0]};
    endfunction

    function automatic logic [6:0] excp_at(input logic [31:0] pc);
        return (pc == rows[row_idx].excp_addr) ? rows[row_idx].excp_code : 7'h00;
    endfunction

    function automatic logic has_ibar(input logic [31:0] pc);
        return (word_at(pc) == frontend_pkg::INST_IBAR) ||
               (word_at(pc + 32'd4) == frontend_pkg::INST_IBAR);
    endfunction

    function automatic logic [31:0] step_pc(input logic [31:0] pc);
        return (word_at(pc) == frontend_pkg::INST_IBAR) ? pc + 32'd4 : pc + 32'd8;
    endfunction

    function automatic frontend_pkg::fetch_resp_t make_resp(input logic [31:0] pc);
        frontend_pkg::fetch_resp_t r;
        r.pc    = pc;
        r.inst0 = word_at(pc);
        r.inst1 = word_at(pc + 32'd4);
        r.excp  = excp_at(pc);
        return r;
    endfunction

    function automatic frontend_pkg::fetch_pkt_t predict_pkt(input logic [31:0] pc);
        frontend_pkg::fetch_pkt_t p;
        p.pc      = pc;
        p.pc_next = pc + 32'd8;
        p.inst0   = word_at(pc);
        p.excp    = excp_at(pc);
        if (word_at(pc) == frontend_pkg::INST_IBAR) begin
            p.inst1      = frontend_pkg::INST_NOP;  // slot1 masked behind barrier
            p.slot_valid = 2'b01;
        end else begin
            p.inst1      = word_at(pc + 32'd4);
            p.slot_valid = 2'b11;
        end
        return p;
    endfunction

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_pc(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: request pc %h, expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_pkt(input frontend_pkg::fetch_pkt_t got,
                               input frontend_pkg::fetch_pkt_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: packet at pc %h differs from expected pc %h",
                     $time, got.pc, exp.pc);
            $display("  got      %h", got);
            $display("  expected %h", exp);
            abort_run();
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // start, ibar, redirect cycle, redirect pc, excp addr, excp code,
    // ex delay, cache delay, dec_ready duty, packets
    task automatic load_rows();
        rows[0] = '{32'h1c00_0000, 32'h0, 32'd0, 32'h0, 32'h0, 7'h00,
                    32'd0, 32'd0, 32'd100, 32'd8};
        rows[1] = '{32'h1c00_1000, 32'h0, 32'd0, 32'h0, 32'h0, 7'h00,
                    32'd0, 32'd0, 32'd50, 32'd12};
        rows[2] = '{32'h1c00_2000, 32'h1c00_2010, 32'd0, 32'h0, 32'h0, 7'h00,
                    32'd3, 32'd5, 32'd80, 32'd6};
        rows[3] = '{32'h1c00_3000, 32'h1c00_300c, 32'd0, 32'h0, 32'h0, 7'h00,
                    32'd2, 32'd1, 32'd70, 32'd5};
        rows[4] = '{32'h1c00_4000, 32'h0, 32'd12, 32'h1c00_8000, 32'h0, 7'h00,
                    32'd0, 32'd0, 32'd60, 32'd6};
        rows[5] = '{32'h1c00_5000, 32'h0, 32'd0, 32'h0, 32'h1c00_5010, 7'h15,
                    32'd0, 32'd0, 32'd100, 32'd5};
    endtask

    task automatic run_row(input int r);
        @(posedge clk);
        row_idx        <= r;
        redirect_valid <= 1'b1;
        redirect_pc    <= rows[r].start_pc;
        @(posedge clk);
        redirect_valid <= 1'b0;
        if (rows[r].redir_cycle != 0) begin
            repeat (rows[r].redir_cycle) @(posedge clk);
            redirect_valid <= 1'b1;
            redirect_pc    <= rows[r].redir_pc;
            @(posedge clk);
            redirect_valid <= 1'b0;
        end
        do @(posedge clk); while (pkt_count < rows[r].n_pkts);
    endtask

    // memory responder and ready gaps, one random stream
    initial begin
        int          mem_dly;
        logic        mem_busy;
        logic [31:0] mem_pc;
        void'($urandom(96));
        mem_busy = 1'b0;
        mem_dly  = 0;
        mem_pc   = '0;
        forever begin
            @(posedge clk);
            imem_resp_valid <= 1'b0;
            imem_req_ready  <= ($urandom % 4) != 0;
            dec_ready       <= ($urandom % 100) < rows[row_idx].duty;
            if (mem_busy) begin
                if (mem_dly == 0) begin
                    imem_resp       <= make_resp(mem_pc);
                    imem_resp_valid <= 1'b1;
                    mem_busy = 1'b0;
                end else begin
                    mem_dly = mem_dly - 1;
                end
            end
            if (rstn && imem_req_valid && imem_req_ready) begin
                mem_pc   = imem_req.pc;
                mem_dly  = $urandom % 4;
                mem_busy = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        ex_ibar_done <= 1'b0;
        cache_idle   <= 1'b0;
        if (rstn && redirect_valid) begin
            exp_req_pc = redirect_pc;
            exp_pkt_pc = redirect_pc;
            blocked    = 1'b0;
            ex_seen    = 1'b0;
            ex_wait    = -1;
            ci_wait    = -1;
            pkt_count <= 0;
        end else if (rstn) begin
            if (imem_req_valid && imem_req_ready) begin
                if (blocked) begin
                    $display("request for %h accepted while a barrier was pending", imem_req.pc);
                    abort_run();
                end
                compare_pc(imem_req.pc, exp_req_pc);
                blocked    = has_ibar(exp_req_pc);
                ex_seen    = 1'b0;
                exp_req_pc = step_pc(exp_req_pc);
            end
            if (ex_ibar_done)
                ex_seen = 1'b1;
            if (cache_idle && ex_seen) begin
                blocked = 1'b0;
                ex_seen = 1'b0;
            end
            if (ci_wait == 0) begin
                cache_idle <= 1'b1;
                ci_wait = -1;
            end else if (ci_wait > 0) begin
                ci_wait = ci_wait - 1;
            end
            if (ex_wait == 0) begin
                ex_ibar_done <= 1'b1;
                ex_wait = -1;
                ci_wait = rows[row_idx].ci_dly;  // cache idle follows execute
            end else if (ex_wait > 0) begin
                ex_wait = ex_wait - 1;
                cache_idle <= 1'b1;  // caches idle early, execute still busy
            end
            if (dec_valid && dec_ready) begin
                compare_pkt(dec_pkt, predict_pkt(exp_pkt_pc));
                if (has_ibar(exp_pkt_pc))
                    ex_wait = rows[row_idx].ex_dly;
                exp_pkt_pc = step_pc(exp_pkt_pc);
                pkt_count <= pkt_count + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, no further packets arrived", cycles);
            abort_run();
        end
    end

    initial begin
        int total;
        load_rows();
        total = 0;
        for (int i = 0; i < NUM_ROWS; i++)
            total = total + rows[i].n_pkts + rows[i].ex_dly + rows[i].ci_dly +
                    rows[i].redir_cycle;
        limit = 40 * total;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        compare_flag(dec_valid, 1'b0, "dec_valid in reset");
        for (int r = 0; r < NUM_ROWS; r++)
            run_row(r);
        $display("All tests passed!");
        $finish;
    end

endmodule

/* vlog.f */
design/frontend_pkg.sv
design/pc_gen.sv
design/predecode.sv
design/ibar_ctrl.sv
design/fetch_stage_reg.sv
design/fetch_buffer.sv
design/fetch_frontend.sv
sim/tb_fetch_frontend.sv

/* Makefile */
SRCS = design/frontend_pkg.sv design/pc_gen.sv design/predecode.sv design/ibar_ctrl.sv \
       design/fetch_stage_reg.sv design/fetch_buffer.sv design/fetch_frontend.sv \
       sim/tb_fetch_frontend.sv

.PHONY: run clean

run: obj_dir/Vtb_fetch_frontend
	./obj_dir/Vtb_fetch_frontend | tee sim.log
	grep -q "All tests passed!" sim.log

obj_dir/Vtb_fetch_frontend: vlog.f $(SRCS)
	verilator --binary --timescale 1ns/1ps --top-module tb_fetch_frontend -f vlog.f

clean:
	rm -rf obj_dir sim.log
